/* source/search_ctrl_pkg.sv */
// search controller shared definitions
// widths, host register map, register selects and the structs between the stages
package search_ctrl_pkg;

   localparam int BOARD_WIDTH      = 256;
   localparam int EVAL_WIDTH       = 24;   // signed
   localparam int HALF_MOVE_WIDTH  = 8;
   localparam int MOVE_INDEX_WIDTH = 8;
   localparam int NODES_WIDTH      = 28;
   localparam int HASH_WIDTH       = 80;
   localparam int REG_ADDR_WIDTH   = 14;   // bus address bits 17:4
   localparam int NUM_TABLES       = 2;
   localparam int BUS_DATA_WIDTH   = 128;
   localparam int BUS_STRB_WIDTH   = BUS_DATA_WIDTH / 8;

   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   localparam reg_addr_t TABLE_STRIDE    = 100;   // main table to quiescence table

   localparam reg_addr_t ADDR_CTRL       = 0;
   localparam reg_addr_t ADDR_MOVE_INDEX = 1;
   localparam reg_addr_t ADDR_SIDE       = 2;
   localparam reg_addr_t ADDR_HALF_MOVE  = 3;
   localparam reg_addr_t ADDR_QUIESCE    = 4;
   localparam reg_addr_t ADDR_BOARD_LO   = 8;
   localparam reg_addr_t ADDR_BOARD_HI   = 9;
   localparam reg_addr_t ADDR_MG_FLAGS   = 132;
   localparam reg_addr_t ADDR_MG_EVAL    = 134;
   localparam reg_addr_t ADDR_MG_COUNT   = 135;
   localparam reg_addr_t ADDR_TT_STATUS  = 512;
   localparam reg_addr_t ADDR_TT_IDLE    = 513;
   localparam reg_addr_t ADDR_TT_ENTRY   = 520;
   localparam reg_addr_t ADDR_TT_CMD     = 521;
   localparam reg_addr_t ADDR_TT_HASH0   = 522;   // two more hash words follow

   typedef enum logic [4:0] {
      SEL_NONE,
      SEL_CTRL,
      SEL_MOVE_INDEX,
      SEL_SIDE,
      SEL_HALF_MOVE,
      SEL_QUIESCE,
      SEL_BOARD_LO,
      SEL_BOARD_HI,
      SEL_MG_FLAGS,
      SEL_MG_EVAL,
      SEL_MG_COUNT,
      SEL_TT_STATUS,
      SEL_TT_IDLE,
      SEL_TT_ENTRY,
      SEL_TT_CMD,
      SEL_TT_HASH0,
      SEL_TT_HASH1,
      SEL_TT_HASH2
   } reg_sel_e;

   // bound kind of a stored entry
   typedef enum logic [1:0] {
      FLAG_NONE,
      FLAG_EXACT,
      FLAG_LOWER,
      FLAG_UPPER
   } trans_flag_e;

   typedef struct packed {
      logic                      en;
      logic [BUS_STRB_WIDTH-1:0] we;
      reg_addr_t                 addr;
      logic [BUS_DATA_WIDTH-1:0] din;
   } bus_req_t;

   typedef struct packed {
      reg_sel_e                  sel;
      logic                      table_idx;   // 0 main, 1 quiescence
      logic                      is_write;
      logic                      is_read;
      logic [BUS_STRB_WIDTH-1:0] we;
      logic [BUS_DATA_WIDTH-1:0] din;
   } dec_req_t;

   typedef struct packed {
      logic [BOARD_WIDTH-1:0]     board;
      logic                       white_to_move;
      logic [3:0]                 castle_mask;
      logic [3:0]                 ep_col;
      logic [HALF_MOVE_WIDTH-1:0] half_move;
   } position_t;

   typedef struct packed {
      logic                        new_board_valid;
      logic                        clear_moves;
      logic                        quiescence;
      logic                        soft_reset;
      logic [MOVE_INDEX_WIDTH-1:0] move_index;
   } move_ctrl_t;

   typedef struct packed {
      logic [EVAL_WIDTH-1:0]  eval;
      logic [7:0]             depth;
      logic [NODES_WIDTH-1:0] nodes;
      trans_flag_e            flag;
      logic                   capture;
   } trans_entry_t;

   // msb first, so the struct lines up with command word bits 3:0
   typedef struct packed {
      logic clear;
      logic hash_only;
      logic store;
      logic lookup;
   } trans_cmd_t;

   typedef struct packed {
      logic                   entry_valid;
      logic                   collision;
      logic                   idle;
      logic [EVAL_WIDTH-1:0]  eval;
      logic [7:0]             depth;
      logic [NODES_WIDTH-1:0] nodes;
      trans_flag_e            flag;
      logic [HASH_WIDTH-1:0]  hash;
   } trans_status_t;

   typedef struct packed {
      logic                        idle;
      logic                        moves_ready;   // all moves generated
      logic                        move_ready;    // move at move_index valid
      logic [MOVE_INDEX_WIDTH-1:0] move_count;
      logic [EVAL_WIDTH-1:0]       eval;
      logic                        white_in_check;
      logic                        black_in_check;
      logic                        capture;
   } movegen_status_t;

endpackage

/* source/ctrl_decode.sv */
`timescale 1ns/1ps
// host register pipeline, stage one
// registers each bus access together with its decoded register select
module ctrl_decode
   import search_ctrl_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  bus_req_t bus,
   output dec_req_t dec
);

   reg_sel_e  sel;
   logic      table_idx;
   reg_addr_t tt_addr;

   always_comb
   begin
      table_idx = bus.addr >= ADDR_TT_STATUS + TABLE_STRIDE;
      // fold the quiescence table back onto the main table addresses
      tt_addr = table_idx ? bus.addr - TABLE_STRIDE : bus.addr;
      case (tt_addr)
         ADDR_CTRL:         sel = SEL_CTRL;
         ADDR_MOVE_INDEX:   sel = SEL_MOVE_INDEX;
         ADDR_SIDE:         sel = SEL_SIDE;
         ADDR_HALF_MOVE:    sel = SEL_HALF_MOVE;
         ADDR_QUIESCE:      sel = SEL_QUIESCE;
         ADDR_BOARD_LO:     sel = SEL_BOARD_LO;
         ADDR_BOARD_HI:     sel = SEL_BOARD_HI;
         ADDR_MG_FLAGS:     sel = SEL_MG_FLAGS;
         ADDR_MG_EVAL:      sel = SEL_MG_EVAL;
         ADDR_MG_COUNT:     sel = SEL_MG_COUNT;
         ADDR_TT_STATUS:    sel = SEL_TT_STATUS;
         ADDR_TT_IDLE:      sel = SEL_TT_IDLE;
         ADDR_TT_ENTRY:     sel = SEL_TT_ENTRY;
         ADDR_TT_CMD:       sel = SEL_TT_CMD;
         ADDR_TT_HASH0:     sel = SEL_TT_HASH0;
         ADDR_TT_HASH0 + 1: sel = SEL_TT_HASH1;
         ADDR_TT_HASH0 + 2: sel = SEL_TT_HASH2;
         default:           sel = SEL_NONE;   // unmapped
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         dec <= '{sel: SEL_NONE, default: '0};
      else
      begin
         dec.sel       <= sel;
         dec.table_idx <= table_idx;
         dec.is_write  <= bus.en && (bus.we != '0);
         dec.is_read   <= bus.en && (bus.we == '0);
         dec.we        <= bus.we;
         dec.din       <= bus.din;
      end
   end

   // a decoded write always carries a nonzero byte enable
   a_write_we : assert property (@(posedge clk) disable iff (!rst_n)
      dec.is_write |-> (dec.we != '0));

endmodule

/* source/position_regs.sv */
`timescale 1ns/1ps
// host register pipeline, write stage for the root position
// holds the board, side word, half move count and the move control bits
module position_regs
   import search_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  dec_req_t   dec,
   output position_t  position,
   output move_ctrl_t move_ctrl
);

   // byte merge of one board half
   function automatic logic [BUS_DATA_WIDTH-1:0] merge_bytes(
      input logic [BUS_DATA_WIDTH-1:0] old_word,
      input logic [BUS_DATA_WIDTH-1:0] din,
      input logic [BUS_STRB_WIDTH-1:0] we
   );
      logic [BUS_DATA_WIDTH-1:0] merged;
      merged = old_word;
      for (int i = 0; i < BUS_STRB_WIDTH; i++)
      begin
         if (we[i])
            merged[i*8 +: 8] = din[i*8 +: 8];
      end
      return merged;
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         move_ctrl <= '0;
      else if (dec.is_write)
      begin
         case (dec.sel)
            SEL_CTRL:
            begin
               move_ctrl.new_board_valid <= dec.din[0];
               move_ctrl.clear_moves     <= dec.din[1];
               move_ctrl.soft_reset      <= dec.din[31];
            end
            SEL_MOVE_INDEX: move_ctrl.move_index <= dec.din[MOVE_INDEX_WIDTH-1:0];
            SEL_QUIESCE:    move_ctrl.quiescence <= dec.din[0];
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         position <= '0;
      else if (dec.is_write)
      begin
         case (dec.sel)
            // side word is {white_to_move, castle_mask, ep_col}
            SEL_SIDE:
               {position.white_to_move, position.castle_mask, position.ep_col} <= dec.din[8:0];
            SEL_HALF_MOVE: position.half_move <= dec.din[HALF_MOVE_WIDTH-1:0];
            SEL_BOARD_LO:
               position.board[BUS_DATA_WIDTH-1:0] <=
                  merge_bytes(position.board[BUS_DATA_WIDTH-1:0], dec.din, dec.we);
            SEL_BOARD_HI:
               position.board[BOARD_WIDTH-1:BUS_DATA_WIDTH] <=
                  merge_bytes(position.board[BOARD_WIDTH-1:BUS_DATA_WIDTH], dec.din, dec.we);
            default:
            begin
            end
         endcase
      end
   end

endmodule

/* source/trans_port.sv */
`timescale 1ns/1ps
// host register pipeline, write stage for one transposition table
// entry fields for a store and self clearing command pulses
module trans_port
   import search_ctrl_pkg::*;
#(
   parameter int TABLE_INDEX = 0   // 0 main, 1 quiescence
)
(
   input  logic         clk,
   input  logic         rst_n,
   input  dec_req_t     dec,
   output trans_entry_t entry,
   output trans_cmd_t   cmd
);

   logic hit;
   logic entry_wr;
   logic cmd_wr;

   assign hit      = dec.is_write && (dec.table_idx == 1'(TABLE_INDEX));
   assign entry_wr = hit && (dec.sel == SEL_TT_ENTRY);
   assign cmd_wr   = hit && (dec.sel == SEL_TT_CMD);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         entry <= '0;
      else if (entry_wr)
      begin
         entry.eval    <= dec.din[EVAL_WIDTH-1:0];
         entry.depth   <= dec.din[31:24];
         entry.nodes   <= dec.din[32 +: NODES_WIDTH];
         // bit 60 is the valid bit on readback, the table sets it itself
         entry.flag    <= trans_flag_e'(dec.din[62:61]);
         entry.capture <= dec.din[63];
      end
   end

   // pulses last one cycle unless the next command write lands right behind
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cmd <= '0;
      else if (cmd_wr)
         cmd <= trans_cmd_t'(dec.din[3:0]);
      else
         cmd <= '0;
   end

   // no command bit stays high two cycles in a row
   a_cmd_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      (cmd != '0) |=> ((cmd & $past(cmd)) == '0));

endmodule

/* source/readback_mux.sv */
`timescale 1ns/1ps
// host register pipeline, read stage
// picks the addressed word and registers it onto dout
module readback_mux
   import search_ctrl_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  dec_req_t                             dec,
   input  position_t                            position,
   input  move_ctrl_t                           move_ctrl,
   input  movegen_status_t                      movegen,
   input  trans_status_t [NUM_TABLES-1:0]       trans_status,
   output logic          [BUS_DATA_WIDTH-1:0]   dout
);

   trans_status_t             ts;
   logic [BUS_DATA_WIDTH-1:0] rd_word;

   assign ts = trans_status[dec.table_idx];

   always_comb
   begin
      rd_word = '0;   // upper bits and unmapped reads stay zero
      case (dec.sel)
         SEL_CTRL:
         begin
            rd_word[0]  = move_ctrl.new_board_valid;
            rd_word[1]  = move_ctrl.clear_moves;
            rd_word[2]  = movegen.moves_ready;
            rd_word[3]  = movegen.move_ready;
            rd_word[7]  = movegen.idle;
            rd_word[31] = move_ctrl.soft_reset;
         end
         SEL_MOVE_INDEX: rd_word[MOVE_INDEX_WIDTH-1:0] = move_ctrl.move_index;
         SEL_SIDE:       rd_word[8:0] = {position.white_to_move, position.castle_mask,
                                         position.ep_col};
         SEL_HALF_MOVE:  rd_word[HALF_MOVE_WIDTH-1:0] = position.half_move;
         SEL_QUIESCE:    rd_word[0] = move_ctrl.quiescence;
         SEL_BOARD_LO:   rd_word = position.board[BUS_DATA_WIDTH-1:0];
         SEL_BOARD_HI:   rd_word = position.board[BOARD_WIDTH-1:BUS_DATA_WIDTH];
         SEL_MG_FLAGS:   rd_word[2:0] = {movegen.black_in_check, movegen.white_in_check,
                                         movegen.capture};
         SEL_MG_EVAL:    rd_word[31:0] = {{(32 - EVAL_WIDTH){movegen.eval[EVAL_WIDTH-1]}},
                                          movegen.eval};
         SEL_MG_COUNT:   rd_word[MOVE_INDEX_WIDTH-1:0] = movegen.move_count;
         // same layout as the entry word, plus valid and collision
         SEL_TT_STATUS:  rd_word[63:0] = {ts.collision, ts.flag, ts.entry_valid, ts.nodes,
                                          ts.depth, ts.eval};
         SEL_TT_IDLE:    rd_word[0] = ts.idle;
         SEL_TT_HASH0:   rd_word[31:0] = ts.hash[31:0];
         SEL_TT_HASH1:   rd_word[31:0] = ts.hash[63:32];
         SEL_TT_HASH2:   rd_word[HASH_WIDTH-65:0] = ts.hash[HASH_WIDTH-1:64];
         default:        rd_word = '0;   // entry and command words are write only
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         dout <= '0;
      else if (dec.is_read)
         dout <= rd_word;   // holds through writes and idle cycles
   end

endmodule

/* source/search_ctrl_top.sv */
`timescale 1ns/1ps
// host register block of the search accelerator
// decode, write and read stages between the host bus and the search engines
module search_ctrl_top
   import search_ctrl_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  bus_req_t                             bus,
   output logic          [BUS_DATA_WIDTH-1:0]   dout,
   output position_t                            position,
   output move_ctrl_t                           move_ctrl,
   input  movegen_status_t                      movegen,
   output trans_entry_t  [NUM_TABLES-1:0]       trans_entry,
   output trans_cmd_t    [NUM_TABLES-1:0]       trans_cmd,
   input  trans_status_t [NUM_TABLES-1:0]       trans_status
);

   dec_req_t dec;

   ctrl_decode ctrl_decode_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus),
      .dec   (dec)
   );

   position_regs position_regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec       (dec),
      .position  (position),
      .move_ctrl (move_ctrl)
   );

   // one port per table, main then quiescence
   for (genvar t = 0; t < NUM_TABLES; t++)
   begin : g_table
      trans_port #(
         .TABLE_INDEX (t)
      ) trans_port_i (
         .clk   (clk),
         .rst_n (rst_n),
         .dec   (dec),
         .entry (trans_entry[t]),
         .cmd   (trans_cmd[t])
      );
   end

   readback_mux readback_mux_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .dec          (dec),
      .position     (position),
      .move_ctrl    (move_ctrl),
      .movegen      (movegen),
      .trans_status (trans_status),
      .dout         (dout)
   );

endmodule

/* bench/bus_tasks.svh */
// host bus tasks for the search controller testbench
// fixed latency accesses, command pulse wait and the board byte merge model
`ifndef BUS_TASKS_SVH
`define BUS_TASKS_SVH

localparam int WAIT_LIMIT = 16;   // cycles before a wait gives up

// every task starts and ends 10 ns after a rising edge
task automatic skip_cycles(input int n);
   repeat (n) @(posedge clk);
   #10;
endtask

task automatic write_reg(input reg_addr_t addr, input logic [127:0] data,
                         input logic [15:0] we);
   bus = '{en: 1'b1, we: we, addr: addr, din: data};
   skip_cycles(1);   // sampled on this edge
   bus = '0;
endtask

task automatic read_reg(input reg_addr_t addr, output logic [127:0] data);
   bus = '{en: 1'b1, we: '0, addr: addr, din: '0};
   skip_cycles(1);
   bus = '0;
   skip_cycles(1);   // second edge of the fixed read latency
   data = dout;
endtask

// counts the cycles until a command pulse of table t shows up
task automatic await_pulse(input int t, output int cycles);
   cycles = 0;
   while ((trans_cmd[t] == '0) && (cycles < WAIT_LIMIT))
   begin
      skip_cycles(1);
      cycles++;
   end
   if (trans_cmd[t] == '0)
   begin
      timeout_count++;
      $display("timeout, no command pulse on table %0d after %0d cycles", t, cycles);
   end
endtask

// expected board half after a write with byte enables
function automatic logic [127:0] byte_merge(input logic [127:0] old_word,
                                            input logic [127:0] din,
                                            input logic [15:0]  we);
   logic [127:0] mask;
   mask = '0;
   for (int b = 0; b < 16; b++)
      mask[b*8 +: 8] = {8{we[b]}};
   return (old_word & ~mask) | (din & mask);
endfunction

`endif

/* bench/search_ctrl_tb.sv */
`timescale 1ns/1ps
// testbench for the search controller host register block
// bus accesses checked against values built from the register map
module search_ctrl_tb
   import search_ctrl_pkg::*;
();

   logic                           clk;
   logic                           rst_n;
   bus_req_t                       bus;
   logic [BUS_DATA_WIDTH-1:0]      dout;
   position_t                      position;
   move_ctrl_t                     move_ctrl;
   movegen_status_t                movegen;
   trans_entry_t  [NUM_TABLES-1:0] trans_entry;
   trans_cmd_t    [NUM_TABLES-1:0] trans_cmd;
   trans_status_t [NUM_TABLES-1:0] trans_status;

   integer seed          = 49595;
   int     error_count   = 0;
   int     timeout_count = 0;

   search_ctrl_top search_ctrl_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus          (bus),
      .dout         (dout),
      .position     (position),
      .move_ctrl    (move_ctrl),
      .movegen      (movegen),
      .trans_entry  (trans_entry),
      .trans_cmd    (trans_cmd),
      .trans_status (trans_status)
   );

   `include "bus_tasks.svh"

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      #100_000;   // far beyond the length of the stimulus
      $display("simulation time limit reached before the stimulus finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic expect_eq(input string name, input logic [511:0] got,
                            input logic [511:0] exp);
      assert (got === exp)
      else
      begin
         error_count++;
         $display("** Error %s: got %0h, expected %0h", name, got, exp);
      end
   endtask

   function automatic logic [255:0] random_bits();
      logic [255:0] value;
      for (int w = 0; w < 8; w++)
         value[w*32 +: 32] = $random(seed);
      return value;
   endfunction

   initial
   begin
      logic [255:0]                   r;
      logic [255:0]                   board_model;
      logic [127:0]                   rd;
      logic [127:0]                   exp;
      logic [31:0]                    ctrl_bits;
      logic [15:0]                    we;
      logic [3:0]                     cmd_bits;
      reg_addr_t                      base;
      int                             cycles;
      position_t                      position_snap;
      move_ctrl_t                     move_ctrl_snap;
      trans_entry_t  [NUM_TABLES-1:0] entry_snap;

      rst_n        = 1'b0;
      bus          = '0;
      movegen      = '0;
      trans_status = '0;
      board_model  = '0;
      repeat (4) @(posedge clk);
      #10;
      rst_n = 1'b1;

      expect_eq("move_ctrl", move_ctrl, '0);
      expect_eq("trans_cmd", trans_cmd, '0);
      expect_eq("dout", dout, '0);
      read_reg(ADDR_CTRL, rd);
      expect_eq("ctrl written bits", rd & 128'h8000_0003, '0);

      // back to back writes, then readback and outputs
      r = random_bits();
      write_reg(ADDR_MOVE_INDEX, r[127:0], '1);
      write_reg(ADDR_SIDE, r[159:32], '1);
      write_reg(ADDR_HALF_MOVE, r[191:64], '1);
      write_reg(ADDR_QUIESCE, r[223:96], '1);
      write_reg(ADDR_CTRL, r[255:128], '1);
      ctrl_bits = r[159:128] & 32'h8000_0003;
      read_reg(ADDR_MOVE_INDEX, rd);
      expect_eq("move_index readback", rd, r[7:0]);
      read_reg(ADDR_SIDE, rd);
      expect_eq("side readback", rd, r[40:32]);
      read_reg(ADDR_HALF_MOVE, rd);
      expect_eq("half_move readback", rd, r[71:64]);
      read_reg(ADDR_QUIESCE, rd);
      expect_eq("quiescence readback", rd, r[96]);
      read_reg(ADDR_CTRL, rd);
      expect_eq("ctrl readback", rd, ctrl_bits);
      expect_eq("move_ctrl.move_index", move_ctrl.move_index, r[7:0]);
      expect_eq("position.white_to_move", position.white_to_move, r[40]);
      expect_eq("position.castle_mask", position.castle_mask, r[39:36]);
      expect_eq("position.ep_col", position.ep_col, r[35:32]);
      expect_eq("position.half_move", position.half_move, r[71:64]);
      expect_eq("move_ctrl.quiescence", move_ctrl.quiescence, r[96]);
      expect_eq("move_ctrl.new_board_valid", move_ctrl.new_board_valid, r[128]);
      expect_eq("move_ctrl.clear_moves", move_ctrl.clear_moves, r[129]);
      expect_eq("move_ctrl.soft_reset", move_ctrl.soft_reset, r[159]);

      for (int i = 0; i < 6; i++)
      begin
         r    = random_bits();
         we   = (r[143:128] == '0) ? 16'h0001 : r[143:128];   // zero would be a read
         base = (i % 2 == 0) ? ADDR_BOARD_LO : ADDR_BOARD_HI;
         board_model[(i % 2)*128 +: 128] = byte_merge(board_model[(i % 2)*128 +: 128],
                                                      r[127:0], we);
         write_reg(base, r[127:0], we);
         skip_cycles(2);
         expect_eq("position.board", position.board, board_model);
      end
      read_reg(ADDR_BOARD_HI, rd);
      expect_eq("board_hi readback", rd, board_model[255:128]);

      for (int t = 0; t < NUM_TABLES; t++)
      begin
         base       = reg_addr_t'(t) * TABLE_STRIDE;
         entry_snap = trans_entry;
         r          = random_bits();
         write_reg(ADDR_TT_ENTRY + base, r[127:0], '1);
         skip_cycles(2);
         expect_eq("entry.eval", trans_entry[t].eval, r[23:0]);
         expect_eq("entry.depth", trans_entry[t].depth, r[31:24]);
         expect_eq("entry.nodes", trans_entry[t].nodes, r[59:32]);
         expect_eq("entry.flag", trans_entry[t].flag, r[62:61]);
         expect_eq("entry.capture", trans_entry[t].capture, r[63]);
         expect_eq("other table entry", trans_entry[1-t], entry_snap[1-t]);
         cmd_bits = (r[67:64] == '0) ? 4'h5 : r[67:64];
         write_reg(ADDR_TT_CMD + base, cmd_bits, '1);
         await_pulse(t, cycles);
         // write_reg already spent the first of the two cycles
         expect_eq("cmd pulse delay", cycles, 1);
         expect_eq("trans_cmd", trans_cmd[t], cmd_bits);
         expect_eq("other table trans_cmd", trans_cmd[1-t], '0);
         skip_cycles(1);
         expect_eq("trans_cmd after pulse", trans_cmd[t], '0);
      end

      r       = random_bits();
      movegen = r[$bits(movegen_status_t)-1:0];
      r       = random_bits();
      trans_status[0] = r[$bits(trans_status_t)-1:0];
      r       = random_bits();
      trans_status[1] = r[$bits(trans_status_t)-1:0];
      read_reg(ADDR_MG_FLAGS, rd);
      expect_eq("mg_flags", rd,
                {movegen.black_in_check, movegen.white_in_check, movegen.capture});
      read_reg(ADDR_MG_EVAL, rd);
      expect_eq("mg_eval", rd, {{8{movegen.eval[23]}}, movegen.eval});
      read_reg(ADDR_MG_COUNT, rd);
      expect_eq("mg_count", rd, movegen.move_count);
      read_reg(ADDR_CTRL, rd);
      expect_eq("ctrl status bits", rd, ctrl_bits | {movegen.idle, 3'b0,
                movegen.move_ready, movegen.moves_ready, 2'b0});
      for (int t = 0; t < NUM_TABLES; t++)
      begin
         base       = reg_addr_t'(t) * TABLE_STRIDE;
         exp        = '0;
         exp[23:0]  = trans_status[t].eval;
         exp[31:24] = trans_status[t].depth;
         exp[59:32] = trans_status[t].nodes;
         exp[60]    = trans_status[t].entry_valid;
         exp[62:61] = trans_status[t].flag;
         exp[63]    = trans_status[t].collision;
         read_reg(ADDR_TT_STATUS + base, rd);
         expect_eq("tt_status", rd, exp);
         read_reg(ADDR_TT_IDLE + base, rd);
         expect_eq("tt_idle", rd, trans_status[t].idle);
         read_reg(ADDR_TT_HASH0 + base, rd);
         expect_eq("tt_hash0", rd, trans_status[t].hash[31:0]);
         read_reg(ADDR_TT_HASH0 + base + reg_addr_t'(1), rd);
         expect_eq("tt_hash1", rd, trans_status[t].hash[63:32]);
         read_reg(ADDR_TT_HASH0 + base + reg_addr_t'(2), rd);
         expect_eq("tt_hash2", rd, trans_status[t].hash[79:64]);
      end

      // 5 and 625 decode to nothing, 625 folds onto 525
      read_reg(5, rd);
      expect_eq("unmapped read", rd, '0);
      read_reg(625, rd);
      expect_eq("unmapped read", rd, '0);
      position_snap  = position;
      move_ctrl_snap = move_ctrl;
      entry_snap     = trans_entry;
      r              = random_bits();
      write_reg(5, r[127:0], '1);
      write_reg(625, r[255:128], '1);
      skip_cycles(2);
      expect_eq("position after unmapped write", position, position_snap);
      expect_eq("move_ctrl after unmapped write", move_ctrl, move_ctrl_snap);
      expect_eq("trans_entry after unmapped write", trans_entry, entry_snap);
      expect_eq("trans_cmd after unmapped write", trans_cmd, '0);
      expect_eq("dout after unmapped write", dout, '0);

      $display("checks done with %0d value errors and %0d timeouts",
               error_count, timeout_count);
      if ((error_count == 0) && (timeout_count == 0))
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* all.f */
+incdir+bench
source/search_ctrl_pkg.sv
source/ctrl_decode.sv
source/position_regs.sv
source/trans_port.sv
source/readback_mux.sv
source/search_ctrl_top.sv
bench/search_ctrl_tb.sv

/* Bender.yml */
package:
  name: search_ctrl

sources:
  - source/search_ctrl_pkg.sv
  - source/ctrl_decode.sv
  - source/position_regs.sv
  - source/trans_port.sv
  - source/readback_mux.sv
  - source/search_ctrl_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/search_ctrl_tb.sv
